/* ooo_issue.f */
+incdir+tests
hdl/isa_ops_pkg.sv
hdl/ooo_types_pkg.sv
hdl/issue_control.sv
hdl/rob_tag_allocator.sv
hdl/reg_status_table.sv
hdl/issue_stage_top.sv
tests/issue_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the issue stage testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f ooo_issue.f \
    --top-module issue_stage_tb -o issue_sim > build.log 2>&1 ||
    { echo "build failed, see build.log"; exit 1; }
./obj_dir/issue_sim > sim.log 2>&1 ||
    { cat sim.log; echo "simulation stopped abnormally"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0

/* tests/issue_model.svh */
/*
  reference model of the register status table and the rob tag queue
  included inside the testbench module, advanced once per rising edge
*/
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

localparam int MODEL_DEPTH = 8; // matches ROB_DEPTH of the dut instance

logic [3:0] m_tag  [32]; // newest producer per register
logic       m_busy [32];
logic [3:0] q_tag  [$];  // outstanding tags, oldest first
logic [4:0] q_dest [$];  // rd of each outstanding tag
logic       q_wr   [$];  // whether it writes rd
int         m_tail;      // next tag to hand out

function automatic logic class_writes_rd(input op_class_e op);
    return (op == OP_ALU) || (op == OP_ALU_IMM) || (op == OP_LOAD);
endfunction

function automatic logic class_reads_rs2(input op_class_e op);
    return (op == OP_ALU) || (op == OP_STORE) || (op == OP_BRANCH);
endfunction

function automatic reg_stat_t lookup_entry(input logic [4:0] r);
    return '{rob_tag: m_tag[r], busy: m_busy[r]};
endfunction

task automatic reset_model();
    for (int i = 0; i < 32; i++) begin
        m_tag[i]  = '0;
        m_busy[i] = 1'b0;
    end
    q_tag.delete();
    q_dest.delete();
    q_wr.delete();
    m_tail = 0;
endtask

// one edge: the oldest tag commits first, then the accepted issue lands
task automatic apply_edge(input issue_req_t r, input logic acc, input logic cv);
    logic [3:0] c_tag;
    logic [4:0] c_dest;
    logic       c_wr;
    logic       same_rd;
    if (cv) begin
        c_tag   = q_tag.pop_front();
        c_dest  = q_dest.pop_front();
        c_wr    = q_wr.pop_front();
        same_rd = acc && class_writes_rd(r.op) && (r.rd == c_dest); // issue wins
        if (c_wr && m_busy[c_dest] && (m_tag[c_dest] == c_tag) && !same_rd) begin
            m_busy[c_dest] = 1'b0;
            m_tag[c_dest]  = '0;
        end
    end
    if (acc) begin
        if (class_writes_rd(r.op) && (r.rd != 5'd0)) begin
            m_busy[r.rd] = 1'b1;
            m_tag[r.rd]  = m_tail[3:0];
        end
        q_tag.push_back(m_tail[3:0]);
        q_dest.push_back(r.rd);
        q_wr.push_back(class_writes_rd(r.op));
        m_tail = (m_tail + 1) % MODEL_DEPTH; // tags wrap at the rob depth
    end
endtask

`endif

/* tests/issue_stage_tb.sv */
/*
  testbench for the issue stage rename lookup
  random issues, commits, stalls and flushes from a fixed seed, checked
  against the model at every falling edge
*/
`timescale 1ns/1ps

module issue_stage_tb;
    import isa_ops_pkg::*;
    import ooo_types_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 10 + 16 + 1 + 2 + 300 + 100 + 200;

    logic       clk;
    logic       reset;
    logic       flush;
    logic       issue_valid;
    logic       stall;
    logic       commit_valid;
    issue_req_t req;
    commit_t    cmt;
    logic       issue_accepted;
    logic       rob_full;
    issue_res_t res;

    integer seed = 89089;
    int     n_checks;
    int     n_errors;

    `include "issue_model.svh"

    issue_stage_top #(.ROB_DEPTH(8)) uut (
        .clk, .reset, .flush, .issue_valid, .req, .stall,
        .commit_valid, .cmt, .issue_accepted, .res, .rob_full
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAILED at %0t: %s got %0h expected %0h", $time, what, actual, expected);
        end
    endtask

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // mostly low registers so rd collisions and x0 come up often
    function automatic logic [4:0] pick_reg();
        return (rand_below(4) == 0) ? 5'(rand_below(32)) : 5'(rand_below(8));
    endfunction

    // check lookups at the falling edge, advance model and inputs at the rising edge
    task automatic step_cycle(input int p_issue, input int p_stall, input int p_commit,
                              input int p_flush);
        reg_stat_t s1;
        reg_stat_t s2;
        logic      k_used;
        logic      exp_acc;
        logic      do_flush;
        logic      do_commit;
        @(negedge clk);
        s1      = lookup_entry(req.rs1);
        s2      = lookup_entry(req.rs2);
        k_used  = class_reads_rs2(req.op);
        exp_acc = issue_valid && !stall && (q_tag.size() < MODEL_DEPTH);
        check_value(rob_full, q_tag.size() == MODEL_DEPTH, "rob_full");
        check_value(issue_accepted, exp_acc, "issue_accepted");
        check_value(res.tag, m_tail, "assigned tag");
        check_value(res.q_j, s1.rob_tag, "q_j");
        check_value(res.j_busy, s1.busy, "j_busy");
        check_value(res.uses_rs2, k_used, "uses_rs2");
        check_value(res.q_k, k_used ? s2.rob_tag : 4'd0, "q_k");
        check_value(res.k_busy, k_used && s2.busy, "k_busy");
        @(posedge clk);
        if (flush)
            reset_model(); // dut clears at this same edge
        else
            apply_edge(req, exp_acc, commit_valid);
        do_flush  = rand_below(100) < p_flush;
        do_commit = !do_flush && (q_tag.size() > 0) && (rand_below(100) < p_commit);
        flush        <= do_flush;
        issue_valid  <= rand_below(100) < p_issue;
        stall        <= rand_below(100) < p_stall;
        req          <= '{op: op_class_e'(rand_below(5)), rs1: pick_reg(),
                          rs2: pick_reg(), rd: pick_reg()};
        commit_valid <= do_commit;
        if (do_commit)
            cmt <= '{tag: q_tag[0], dest: q_dest[0], reg_write: q_wr[0]}; // oldest only
        else
            cmt <= '0;
    endtask

    task automatic run_test(input string name, input int cycles, input int p_issue,
                            input int p_stall, input int p_commit, input int p_flush);
        int err_before;
        err_before = n_errors;
        repeat (cycles) step_cycle(p_issue, p_stall, p_commit, p_flush);
        $display("test %-14s %4d cycles, %0d errors", name, cycles, n_errors - err_before);
    endtask

    // watchdog sized from the planned cycle count
    initial begin
        #((TOTAL_CYCLES + 100) * CLK_PERIOD);
        $display("timeout: run did not finish within the expected cycle count");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        reset        = 1'b1;
        flush        = 1'b0;
        issue_valid  = 1'b0;
        stall        = 1'b0;
        commit_valid = 1'b0;
        req          = '0;
        cmt          = '0;
        n_checks     = 0;
        n_errors     = 0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        run_test("reset_lookup", 10, 0, 0, 0, 0);
        run_test("issue_only", 16, 100, 0, 0, 0);    // fills the rob and stays blocked
        run_test("one_commit", 1, 0, 0, 100, 0);
        run_test("after_commit", 2, 0, 0, 0, 0);     // rob_full drops after the commit edge
        run_test("commit_mix", 300, 60, 0, 50, 0);
        run_test("stall", 100, 80, 50, 40, 0);
        run_test("flush", 200, 60, 20, 40, 3);
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* hdl/issue_stage_top.sv */
/*
  issue stage rename lookup, top level
  joins issue control, rob tag allocator and register status table
  and packs the issue result for the reservation stations
*/
`timescale 1ns/1ps

module issue_stage_top #(
    parameter int ROB_DEPTH = 8 // 2 to 16
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     issue_valid,
    input  isa_ops_pkg::issue_req_t  req,
    input  logic                     stall,
    input  logic                     commit_valid,
    input  ooo_types_pkg::commit_t   cmt,
    output logic                     issue_accepted,
    output ooo_types_pkg::issue_res_t res,
    output logic                     rob_full
);
    import ooo_types_pkg::*;

    logic      accept;
    logic      dest_write;
    logic      uses_rs2;
    rob_tag_t  alloc_tag;
    reg_stat_t stat_rs1;
    reg_stat_t stat_rs2;

    issue_control u_ctrl (
        .req         (req),
        .issue_valid (issue_valid),
        .stall       (stall),
        .rob_full    (rob_full),
        .accept      (accept),
        .dest_write  (dest_write),
        .uses_rs2    (uses_rs2)
    );

    rob_tag_allocator #(.ROB_DEPTH(ROB_DEPTH)) u_alloc (
        .clk, .reset, .flush,
        .alloc        (accept),
        .commit_valid (commit_valid),
        .commit_tag   (cmt.tag),
        .alloc_tag    (alloc_tag),
        .rob_full     (rob_full)
    );

    reg_status_table u_table (
        .clk, .reset, .flush,
        .rs1 (req.rs1), .rs2 (req.rs2),
        .issue_dest  (req.rd),
        .issue_write (dest_write),
        .issue_tag   (alloc_tag),
        .commit_valid, .cmt,
        .stat_rs1, .stat_rs2
    );

    assign issue_accepted = accept;

    always_comb begin
        res.tag      = alloc_tag;
        res.q_j      = stat_rs1.rob_tag;
        res.j_busy   = stat_rs1.busy;
        res.q_k      = uses_rs2 ? stat_rs2.rob_tag : '0; // immediate slot reads ready
        res.k_busy   = uses_rs2 && stat_rs2.busy;
        res.uses_rs2 = uses_rs2;
    end

endmodule

/* hdl/reg_status_table.sv */
/*
  32-entry register status table
  marks the issued rd busy with its rob tag and clears it on commit only when
  the committing tag is still the newest writer, lookups are combinational
*/
`timescale 1ns/1ps

module reg_status_table (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush,        // mispredict recovery, clears all
    input  logic [4:0]               rs1,
    input  logic [4:0]               rs2,
    input  logic [4:0]               issue_dest,
    input  logic                     issue_write,  // accepted issue that writes rd
    input  ooo_types_pkg::rob_tag_t  issue_tag,
    input  logic                     commit_valid,
    input  ooo_types_pkg::commit_t   cmt,
    output ooo_types_pkg::reg_stat_t stat_rs1,
    output ooo_types_pkg::reg_stat_t stat_rs2
);
    import ooo_types_pkg::*;

    reg_stat_t   entries [32]; // current table contents
    reg_stat_t   new_entry;    // value written for the issuing rd
    logic [31:0] write_bus;    // one-hot issue write
    logic [31:0] clear_bus;    // one-hot commit clear
    logic        newest_writer;
    logic        clear_en;

    always_comb begin
        new_entry.rob_tag = issue_tag;
        new_entry.busy    = 1'b1;
    end

    // x0 is never renamed
    always_comb begin
        write_bus = '0;
        if (issue_write && (issue_dest != 5'd0))
            write_bus[issue_dest] = 1'b1;
    end

    // a later writer may have retagged the register since this commit issued
    assign newest_writer = entries[cmt.dest].busy && (entries[cmt.dest].rob_tag == cmt.tag);

    // same-cycle issue to the same rd keeps the new tag
    assign clear_en = commit_valid && cmt.reg_write && newest_writer &&
                      !(issue_write && (issue_dest == cmt.dest));

    always_comb begin
        clear_bus = '0;
        if (clear_en && (cmt.dest != 5'd0))
            clear_bus[cmt.dest] = 1'b1;
    end

    assign entries[0] = '0; // tag reads zero, never busy

    for (genvar i = 1; i < 32; i++) begin : g_entry
        reg_stat_t entry_q;

        always_ff @(posedge clk) begin
            if (reset || flush)
                entry_q <= '0;
            else if (clear_bus[i])
                entry_q <= '0;
            else if (write_bus[i])
                entry_q <= new_entry;
        end

        assign entries[i] = entry_q;
    end

    // lookups see the state before this edge, no bypass of same-cycle updates
    assign stat_rs1 = entries[rs1];
    assign stat_rs2 = entries[rs2];

    // an issue write shows up one edge later unless a flush wipes it
    a_write_visible: assert property (@(posedge clk) disable iff (reset)
        (issue_write && (issue_dest != 5'd0) && !flush) |=>
            (entries[$past(issue_dest)].busy &&
             entries[$past(issue_dest)].rob_tag == $past(issue_tag)))
        else $error("issued rd not busy with its tag one cycle later");

endmodule

/* hdl/rob_tag_allocator.sv */
/*
  in-order circular allocator of rob tags
  hands out the tail tag on alloc, frees the head tag on commit, flush empties it
  rob_full is the occupancy reaching ROB_DEPTH
*/
`timescale 1ns/1ps

module rob_tag_allocator #(
    parameter int ROB_DEPTH = 8 // 2 to 16
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    alloc,        // accepted issue this cycle
    input  logic                    commit_valid,
    input  ooo_types_pkg::rob_tag_t commit_tag,
    output ooo_types_pkg::rob_tag_t alloc_tag,
    output logic                    rob_full
);
    import ooo_types_pkg::*;

    localparam int CNT_W = $clog2(ROB_DEPTH + 1); // count goes up to ROB_DEPTH

    rob_tag_t   head;  // oldest outstanding tag
    rob_tag_t   tail;  // next tag to hand out
    logic [CNT_W-1:0] count;

    // wrap at ROB_DEPTH rather than at the tag width
    function automatic rob_tag_t next_ptr(input rob_tag_t ptr);
        rob_tag_t nxt;
        if (ptr == rob_tag_t'(ROB_DEPTH - 1))
            nxt = '0;
        else
            nxt = ptr + 1'b1;
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc)
                tail <= next_ptr(tail);
            if (commit_valid)
                head <= next_ptr(head);
            // both in one cycle leave the count as it is
            case ({alloc, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign alloc_tag = tail;
    assign rob_full  = (count == CNT_W'(ROB_DEPTH));

    // commits come from the rob head in program order
    a_commit_is_head: assert property (@(posedge clk) disable iff (reset || flush)
        commit_valid |-> commit_tag == head)
        else $error("commit tag %0d is not the oldest tag %0d", commit_tag, head);

    a_no_commit_empty: assert property (@(posedge clk) disable iff (reset || flush)
        commit_valid |-> count != '0)
        else $error("commit while rob empty");

    // issue control gates alloc with rob_full, so this covers the wiring too
    a_no_alloc_full: assert property (@(posedge clk) disable iff (reset || flush)
        alloc |-> !rob_full)
        else $error("tag allocated while rob full");

endmodule

/* hdl/issue_control.sv */
/*
  issue control
  decodes the op class into rd write and rs2 use flags and decides acceptance
  purely combinational, the instruction is taken when valid with no stall and rob room
*/
`timescale 1ns/1ps

module issue_control (
    input  isa_ops_pkg::issue_req_t req,
    input  logic                    issue_valid,
    input  logic                    stall,    // reservation stations full
    input  logic                    rob_full,
    output logic                    accept,
    output logic                    dest_write,
    output logic                    uses_rs2
);
    import isa_ops_pkg::*;

    logic writes_rd; // class produces a register result

    // class decode
    always_comb begin
        writes_rd = 1'b0;
        uses_rs2  = 1'b0;
        case (req.op)
            OP_ALU: begin
                writes_rd = 1'b1;
                uses_rs2  = 1'b1;
            end
            OP_ALU_IMM: begin
                writes_rd = 1'b1; // rs2 slot carries the immediate
            end
            OP_LOAD: begin
                writes_rd = 1'b1;
            end
            OP_STORE: begin
                uses_rs2 = 1'b1; // store data comes from rs2
            end
            OP_BRANCH: begin
                uses_rs2 = 1'b1;
            end
            default: begin
                writes_rd = 1'b0; // unused encodings issue as no-ops
                uses_rs2  = 1'b0;
            end
        endcase
    end

    // accept only with no back-pressure from either side
    assign accept = issue_valid && !stall && !rob_full;

    // rd write only for accepted writers, so a held instruction marks nothing
    assign dest_write = accept && writes_rd;

endmodule

/* hdl/ooo_types_pkg.sv */
/*
  out-of-order bookkeeping types shared by allocator, status table and top
  tags, status entries, commit info and the issue result bundle
*/
package ooo_types_pkg;

    localparam int ROB_TAG_W = 4; // enough for a rob of up to 16 entries

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // one register status entry
    typedef struct packed {
        rob_tag_t rob_tag; // newest producer of this register
        logic     busy;    // value still pending in the rob
    } reg_stat_t;

    // commit info from the rob head
    typedef struct packed {
        rob_tag_t   tag;
        logic [4:0] dest;
        logic       reg_write; // 0 for stores and branches
    } commit_t;

    // what the reservation stations get for an accepted instruction
    typedef struct packed {
        rob_tag_t tag;      // rob slot assigned to this instruction
        rob_tag_t q_j;      // producer of rs1, valid when j_busy
        rob_tag_t q_k;      // producer of rs2, valid when k_busy
        logic     j_busy;
        logic     k_busy;
        logic     uses_rs2; // low means rs2 field holds an immediate or nothing
    } issue_res_t;

endpackage

/* hdl/isa_ops_pkg.sv */
/*
  instruction-side types for the issue stage
  op classes and the decoded request handed over by the decoder
*/
package isa_ops_pkg;

    // coarse instruction class, enough to pick rd write and rs2 use
    typedef enum logic [2:0] {
        OP_ALU     = 3'd0, // reg-reg arithmetic, writes rd
        OP_ALU_IMM = 3'd1, // reg-imm arithmetic, rs2 field is immediate
        OP_LOAD    = 3'd2, // writes rd, address from rs1 + imm
        OP_STORE   = 3'd3, // reads rs1 and rs2, no rd
        OP_BRANCH  = 3'd4  // compares rs1 and rs2, no rd
    } op_class_e;

    // one decoded instruction waiting to issue
    // 18 bits total
    typedef struct packed {
        op_class_e  op;
        logic [4:0] rs1;
        logic [4:0] rs2; // ignored unless the class reads a second register
        logic [4:0] rd;  // ignored for stores and branches
    } issue_req_t;

endpackage
